// File: hdl/aa_bridge.sv
// --------------------
// AXI-Lite to AXI-Stream bridge top with mailbox and interrupt
// --------------------
`default_nettype none
`include "aa_defs.svh"

module aa_bridge import aa_pkg::*; (
  input  logic                   axis_clk,
  input  logic                   axis_rst_n,
  input  logic                   cc_aa_enable,
  // AXI-Lite slave
  input  logic                   s_awvalid,
  input  logic [`AA_LADDR_W-1:0] s_awaddr,
  input  logic                   s_wvalid,
  input  aa_word_t               s_wdata,
  input  aa_strb_t               s_wstrb,
  input  logic                   s_arvalid,
  input  logic [`AA_LADDR_W-1:0] s_araddr,
  input  logic                   s_rready,
  output logic                   s_awready,
  output logic                   s_wready,
  output logic                   s_arready,
  output logic                   s_rvalid,
  output aa_word_t               s_rdata,
  // AXI-Lite master
  output logic                   m_awvalid,
  output aa_word_t               m_awaddr,
  output logic                   m_wvalid,
  output aa_word_t               m_wdata,
  output aa_strb_t               m_wstrb,
  output logic                   m_arvalid,
  output aa_word_t               m_araddr,
  output logic                   m_rready,
  input  logic                   m_awready,
  input  logic                   m_wready,
  input  logic                   m_arready,
  input  logic                   m_rvalid,
  input  aa_word_t               m_rdata,
  // stream in
  input  logic                   as_aa_tvalid,
  input  aa_word_t               as_aa_tdata,
  input  aa_strb_t               as_aa_tstrb,
  input  aa_tuser_e              as_aa_tuser,
  output logic                   aa_as_tready,
  // stream out
  output logic                   aa_as_tvalid,
  output aa_word_t               aa_as_tdata,
  output aa_strb_t               aa_as_tstrb,
  output aa_tuser_e              aa_as_tuser,
  input  logic                   as_aa_tready,
  output logic                   mb_irq
);

  // busy handshake and stream ready terms
  logic       ls_busy, ss_busy, cpl_ready, req_ready;
  // register ports
  logic       lw_en, rw_en;
  logic [8:0] lw_addr, rw_addr, lr_addr;
  aa_word_t   lw_data, rw_data, reg_rdata;
  aa_strb_t   lw_strb, rw_strb;
  // per-path beats
  logic       ls_tvalid, ss_tvalid;
  aa_word_t   ls_tdata, ss_tdata;
  aa_strb_t   ls_tstrb;
  aa_tuser_e  ls_tuser;

  aa_regs       u_regs (.*);
  ls_stream_req u_ls   (.*);
  ss_lite_req   u_ss   (.*);
  stream_tx_mux u_mux  (.*);

  // request beats and completions share the one input ready
  assign aa_as_tready = req_ready | cpl_ready;

  // a completion taken by the local path carries a full strobe
  a_cpl_strb: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    cpl_ready |-> as_aa_tstrb == {`AA_STRB_W{1'b1}})
    else $error("aa_bridge: completion beat with partial strobe");

endmodule

`default_nettype wire

// File: hdl/aa_defs.svh
// --------------------
// bridge widths, tuser beat codes and address windows
// --------------------
`ifndef AA_DEFS_SVH
`define AA_DEFS_SVH

// bus widths
`define AA_DATA_W  32
`define AA_STRB_W  4
`define AA_LADDR_W 15
// address field carried in beat bits 27:0
`define AA_RADDR_W 28

// tuser beat kinds
`define AA_TUSER_WRITE  2'b01
`define AA_TUSER_RD_REQ 2'b10
`define AA_TUSER_RD_CPL 2'b11

// local window, addr[14:12] picks the block and addr[11:8] the target
`define AA_WIN_BLOCK 3'b010
`define AA_WIN_MBOX  4'h0
`define AA_WIN_REG   4'h1

// stream address bits 27:8 of the same targets seen from the remote side
`define AA_REMOTE_MBOX 20'h00020
`define AA_REMOTE_REG  20'h00021

`define AA_MBOX_DEPTH 8

`endif

// File: hdl/aa_pkg.sv
// --------------------
// shared types of the AXI-Lite / AXI-Stream bridge
// --------------------
`default_nettype none
`include "aa_defs.svh"

package aa_pkg;

  typedef logic [`AA_DATA_W-1:0] aa_word_t;
  typedef logic [`AA_STRB_W-1:0] aa_strb_t;

  // beat kind on tuser
  typedef enum logic [1:0] {
    TU_WRITE  = `AA_TUSER_WRITE,
    TU_RD_REQ = `AA_TUSER_RD_REQ,
    TU_RD_CPL = `AA_TUSER_RD_CPL
  } aa_tuser_e;

  // local AXI-Lite slave FSM
  typedef enum logic [3:0] {
    LS_IDLE, LS_WR, LS_WR_B1, LS_WR_B2, LS_W_DONE,
    LS_RD, LS_RD_REQ, LS_RD_WAIT, LS_R_DONE
  } ls_state_e;

  // stream slave / AXI-Lite master FSM
  typedef enum logic [2:0] {
    SS_IDLE, SS_WR_B2, SS_REG, SS_WR_LM, SS_RD_AR, SS_RD_R, SS_CPL
  } ss_state_e;

endpackage

`default_nettype wire

// File: hdl/aa_regs.sv
// --------------------
// mailbox words and interrupt enable/status of the bridge
// local and remote write ports, one local read port
// --------------------
`default_nettype none
`include "aa_defs.svh"

module aa_regs import aa_pkg::*; (
  input  logic       axis_clk,
  input  logic       axis_rst_n,
  input  logic       lw_en,
  input  logic [8:0] lw_addr,
  input  aa_word_t   lw_data,
  input  aa_strb_t   lw_strb,
  input  logic       rw_en,
  input  logic [8:0] rw_addr,
  input  aa_word_t   rw_data,
  input  aa_strb_t   rw_strb,
  input  logic [8:0] lr_addr,
  output aa_word_t   reg_rdata,
  output logic       mb_irq
);

  // addr bit 8 selects the interrupt block, bits 4:2 the mailbox word
  aa_word_t   mbox [`AA_MBOX_DEPTH];
  logic       intr_enable;
  logic       intr_status;
  logic       lw_mbox;
  logic       mb_we;
  logic [2:0] mb_idx;
  aa_word_t   mb_wdata;
  aa_strb_t   mb_wstrb;
  logic       st_clr;
  logic       st_set;

  // local side wins the mailbox when both land together
  assign lw_mbox  = lw_en & ~lw_addr[8];
  assign mb_we    = lw_mbox | (rw_en & ~rw_addr[8]);
  assign mb_idx   = lw_mbox ? lw_addr[4:2] : rw_addr[4:2];
  assign mb_wdata = lw_mbox ? lw_data : rw_data;
  assign mb_wstrb = lw_mbox ? lw_strb : rw_strb;

  always_ff @(posedge axis_clk) begin
    if (mb_we) begin
      for (int b = 0; b < `AA_STRB_W; b++) begin
        if (mb_wstrb[b]) mbox[mb_idx][8*b +: 8] <= mb_wdata[8*b +: 8];
      end
    end
  end

  // status is write-one-to-clear locally, set by any remote mailbox write
  assign st_clr = lw_en & lw_addr[8] & lw_addr[2] & lw_strb[0] & lw_data[0];
  assign st_set = rw_en & ~rw_addr[8] & (|rw_strb);

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      intr_enable <= 1'b0;
      intr_status <= 1'b0;
    end else begin
      if (st_clr) intr_status <= 1'b0;
      else if (st_set) intr_status <= 1'b1;
      // enable at offset 0, byte lane 0
      if (lw_en & lw_addr[8] & ~lw_addr[2] & lw_strb[0]) intr_enable <= lw_data[0];
      else if (rw_en & rw_addr[8] & ~rw_addr[2] & rw_strb[0]) intr_enable <= rw_data[0];
    end
  end

  assign reg_rdata = lr_addr[8] ?
    {{(`AA_DATA_W-1){1'b0}}, (lr_addr[2] ? intr_status : intr_enable)} : mbox[lr_addr[4:2]];

  assign mb_irq = intr_enable & intr_status;

  // both request FSMs must hand over a settled offset with each strobe
  a_lw_addr_known: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    lw_en |-> !$isunknown({lw_addr, lw_strb}))
    else $error("aa_regs: local write with unknown address");
  a_rw_addr_known: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    rw_en |-> !$isunknown({rw_addr, rw_strb}))
    else $error("aa_regs: remote write with unknown address");

endmodule

`default_nettype wire

// File: hdl/ls_stream_req.sv
// --------------------
// local AXI-Lite slave, serves the bridge window or forwards as stream beats
// --------------------
`default_nettype none
`include "aa_defs.svh"

module ls_stream_req import aa_pkg::*; (
  input  logic                   axis_clk,
  input  logic                   axis_rst_n,
  input  logic                   cc_aa_enable,
  input  logic                   ss_busy,
  input  logic                   s_awvalid,
  input  logic [`AA_LADDR_W-1:0] s_awaddr,
  input  logic                   s_wvalid,
  input  aa_word_t               s_wdata,
  input  aa_strb_t               s_wstrb,
  input  logic                   s_arvalid,
  input  logic [`AA_LADDR_W-1:0] s_araddr,
  input  logic                   s_rready,
  output logic                   s_awready,
  output logic                   s_wready,
  output logic                   s_arready,
  output logic                   s_rvalid,
  output aa_word_t               s_rdata,
  input  logic                   as_aa_tvalid,
  input  aa_word_t               as_aa_tdata,
  input  aa_tuser_e              as_aa_tuser,
  input  logic                   as_aa_tready,
  input  aa_word_t               reg_rdata,
  output logic                   ls_busy,
  output logic                   cpl_ready,
  output logic                   lw_en,
  output logic [8:0]             lw_addr,
  output aa_word_t               lw_data,
  output aa_strb_t               lw_strb,
  output logic [8:0]             lr_addr,
  output logic                   ls_tvalid,
  output aa_word_t               ls_tdata,
  output aa_strb_t               ls_tstrb,
  output aa_tuser_e              ls_tuser
);

  ls_state_e              ls_state;
  logic [`AA_LADDR_W-1:0] addr_q;
  aa_word_t               data_q;
  aa_strb_t               strb_q;
  aa_word_t               cpl_q;
  logic                   start_wr;
  logic                   start;
  logic                   hit_mbox;
  logic                   hit_local;
  logic [`AA_RADDR_W-1:0] raddr;

  // write wins when aw/w and ar show up together
  assign start_wr  = s_awvalid & s_wvalid;
  assign start     = cc_aa_enable & ~ss_busy & (start_wr | s_arvalid);
  assign hit_mbox  = (addr_q[14:12] == `AA_WIN_BLOCK) && (addr_q[11:8] == `AA_WIN_MBOX);
  assign hit_local = hit_mbox ||
                     ((addr_q[14:12] == `AA_WIN_BLOCK) && (addr_q[11:8] == `AA_WIN_REG));
  assign raddr     = {{(`AA_RADDR_W-`AA_LADDR_W){1'b0}}, addr_q};

  // completion accepted only while a forwarded read waits for it
  assign cpl_ready = (ls_state == LS_RD_WAIT) & as_aa_tvalid & (as_aa_tuser == TU_RD_CPL);

  // --------------------
  // FSM
  // --------------------
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      ls_state <= LS_IDLE;
    end else begin
      case (ls_state)
        LS_IDLE:    if (start) ls_state <= start_wr ? LS_WR : LS_RD;
        LS_WR:      ls_state <= hit_local ? LS_W_DONE : LS_WR_B1;
        LS_WR_B1:   if (as_aa_tready) ls_state <= LS_WR_B2;
        // mailbox already acked before its beats went out
        LS_WR_B2:   if (as_aa_tready) ls_state <= hit_mbox ? LS_IDLE : LS_W_DONE;
        LS_W_DONE:  ls_state <= hit_mbox ? LS_WR_B1 : LS_IDLE;
        LS_RD:      ls_state <= hit_local ? LS_R_DONE : LS_RD_REQ;
        LS_RD_REQ:  if (as_aa_tready) ls_state <= LS_RD_WAIT;
        LS_RD_WAIT: if (cpl_ready) ls_state <= LS_R_DONE;
        LS_R_DONE:  if (s_rready) ls_state <= LS_IDLE;
        default:    ls_state <= LS_IDLE;
      endcase
    end
  end

  // payload latches
  always_ff @(posedge axis_clk) begin
    if ((ls_state == LS_IDLE) && start) begin
      addr_q <= start_wr ? s_awaddr : s_araddr;
      data_q <= s_wdata;
      strb_q <= s_wstrb;
    end
    if (cpl_ready) cpl_q <= as_aa_tdata;
  end

  // AXI-Lite slave side
  assign s_awready = (ls_state == LS_W_DONE);
  assign s_wready  = s_awready;
  assign s_arready = (ls_state == LS_RD);
  assign s_rvalid  = (ls_state == LS_R_DONE);
  assign s_rdata   = hit_local ? reg_rdata : cpl_q;
  assign ls_busy   = (ls_state != LS_IDLE);

  // register port, write lands on the ack cycle
  assign lw_en   = s_awready & hit_local;
  assign lw_addr = addr_q[8:0];
  assign lw_data = data_q;
  assign lw_strb = strb_q;
  assign lr_addr = addr_q[8:0];

  // --------------------
  // outgoing beats
  // --------------------
  assign ls_tvalid = (ls_state == LS_WR_B1) || (ls_state == LS_WR_B2) ||
                     (ls_state == LS_RD_REQ);
  assign ls_tdata  = (ls_state == LS_WR_B1) ? {strb_q, raddr} :
                     (ls_state == LS_WR_B2) ? data_q : {{`AA_STRB_W{1'b0}}, raddr};
  assign ls_tstrb  = (ls_state == LS_RD_REQ) ? {`AA_STRB_W{1'b1}} : strb_q;
  assign ls_tuser  = (ls_state == LS_RD_REQ) ? TU_RD_REQ : TU_WRITE;

  // read data shows one cycle after the accept pulse or the completion beat
  a_rvalid_order: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    $rose(s_rvalid) |-> !s_arready && $past(s_arready || cpl_ready))
    else $error("ls_stream_req: s_rvalid rose out of order");

endmodule

`default_nettype wire

// File: hdl/ss_lite_req.sv
// --------------------
// stream slave, applies remote register writes or runs AXI-Lite master cycles
// --------------------
`default_nettype none
`include "aa_defs.svh"

module ss_lite_req import aa_pkg::*; (
  input  logic       axis_clk,
  input  logic       axis_rst_n,
  input  logic       ls_busy,
  input  logic       as_aa_tvalid,
  input  aa_word_t   as_aa_tdata,
  input  aa_tuser_e  as_aa_tuser,
  input  logic       as_aa_tready,
  output logic       m_awvalid,
  output aa_word_t   m_awaddr,
  output logic       m_wvalid,
  output aa_word_t   m_wdata,
  output aa_strb_t   m_wstrb,
  output logic       m_arvalid,
  output aa_word_t   m_araddr,
  output logic       m_rready,
  input  logic       m_awready,
  input  logic       m_wready,
  input  logic       m_arready,
  input  logic       m_rvalid,
  input  aa_word_t   m_rdata,
  output logic       ss_busy,
  output logic       req_ready,
  output logic       rw_en,
  output logic [8:0] rw_addr,
  output aa_word_t   rw_data,
  output aa_strb_t   rw_strb,
  output logic       ss_tvalid,
  output aa_word_t   ss_tdata
);

  ss_state_e              ss_state;
  logic [`AA_RADDR_W-1:0] addr_q;
  aa_strb_t               strb_q;
  aa_word_t               data_q;
  aa_word_t               rdata_q;
  logic                   take_wr;
  logic                   take_rd;
  logic                   take_data;
  logic                   hit_mbox;
  logic                   hit_reg;
  aa_word_t               lm_addr;

  // beat 1 taken straight from idle, reads wait for the local side to drain
  assign take_wr   = (ss_state == SS_IDLE) & as_aa_tvalid & (as_aa_tuser == TU_WRITE);
  assign take_rd   = (ss_state == SS_IDLE) & as_aa_tvalid & (as_aa_tuser == TU_RD_REQ) &
                     ~ls_busy;
  assign take_data = (ss_state == SS_WR_B2) & as_aa_tvalid;
  assign req_ready = take_wr | take_rd | take_data;
  // accept term included so a local start never races a remote read
  assign ss_busy   = (ss_state != SS_IDLE) | req_ready;

  assign hit_mbox = (addr_q[`AA_RADDR_W-1:8] == `AA_REMOTE_MBOX);
  assign hit_reg  = (addr_q[`AA_RADDR_W-1:8] == `AA_REMOTE_REG);

  // --------------------
  // FSM
  // --------------------
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      ss_state <= SS_IDLE;
    end else begin
      case (ss_state)
        SS_IDLE:  if (take_wr) ss_state <= SS_WR_B2;
                  else if (take_rd) ss_state <= SS_RD_AR;
        SS_WR_B2: if (take_data) ss_state <= (hit_mbox | hit_reg) ? SS_REG : SS_WR_LM;
        SS_REG:   ss_state <= SS_IDLE;
        SS_WR_LM: if (m_awready & m_wready) ss_state <= SS_IDLE;
        SS_RD_AR: if (m_arready) ss_state <= SS_RD_R;
        SS_RD_R:  if (m_rvalid) ss_state <= SS_CPL;
        SS_CPL:   if (as_aa_tready) ss_state <= SS_IDLE;
        default:  ss_state <= SS_IDLE;
      endcase
    end
  end

  // beat 1 gives strobe and address, beat 2 the data word
  always_ff @(posedge axis_clk) begin
    if (take_wr | take_rd) begin
      addr_q <= as_aa_tdata[`AA_RADDR_W-1:0];
      strb_q <= as_aa_tdata[`AA_DATA_W-1:`AA_RADDR_W];
    end
    if (take_data) data_q <= as_aa_tdata;
    if ((ss_state == SS_RD_R) & m_rvalid) rdata_q <= m_rdata;
  end

  // AXI-Lite master, top nibble of the address is zero
  assign lm_addr   = {{(`AA_DATA_W-`AA_RADDR_W){1'b0}}, addr_q};
  assign m_awvalid = (ss_state == SS_WR_LM);
  assign m_wvalid  = m_awvalid;
  assign m_awaddr  = lm_addr;
  assign m_wdata   = data_q;
  assign m_wstrb   = strb_q;
  assign m_arvalid = (ss_state == SS_RD_AR);
  assign m_araddr  = lm_addr;
  assign m_rready  = (ss_state == SS_RD_R);

  // register port, bit 8 flags the interrupt block
  assign rw_en   = (ss_state == SS_REG);
  assign rw_addr = {hit_reg, addr_q[7:0]};
  assign rw_data = data_q;
  assign rw_strb = strb_q;

  // read completion beat
  assign ss_tvalid = (ss_state == SS_CPL);
  assign ss_tdata  = rdata_q;

  a_aw_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    m_awvalid && !(m_awready && m_wready) |=> m_awvalid && m_wvalid && $stable(m_awaddr))
    else $error("ss_lite_req: master write dropped before handshake");

endmodule

`default_nettype wire

// File: hdl/stream_tx_mux.sv
// --------------------
// merges local request beats and remote completions onto one stream
// --------------------
`default_nettype none
`include "aa_defs.svh"

module stream_tx_mux import aa_pkg::*; (
  input  logic      axis_clk,
  input  logic      axis_rst_n,
  input  logic      ls_tvalid,
  input  aa_word_t  ls_tdata,
  input  aa_strb_t  ls_tstrb,
  input  aa_tuser_e ls_tuser,
  input  logic      ss_tvalid,
  input  aa_word_t  ss_tdata,
  input  logic      as_aa_tready,
  output logic      aa_as_tvalid,
  output aa_word_t  aa_as_tdata,
  output aa_strb_t  aa_as_tstrb,
  output aa_tuser_e aa_as_tuser
);

  // remote path only ever sends completions
  assign aa_as_tvalid = ls_tvalid | ss_tvalid;
  assign aa_as_tdata  = ss_tvalid ? ss_tdata : ls_tdata;
  assign aa_as_tstrb  = ss_tvalid ? {`AA_STRB_W{1'b1}} : ls_tstrb;
  assign aa_as_tuser  = ss_tvalid ? TU_RD_CPL : ls_tuser;

  // busy handshake between the two FSMs keeps them apart
  a_no_overlap: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    !(ls_tvalid && ss_tvalid))
    else $error("stream_tx_mux: both paths offered a beat");
  a_beat_stable: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    aa_as_tvalid && !as_aa_tready |=> aa_as_tvalid && $stable(aa_as_tdata) &&
    $stable(aa_as_tstrb) && $stable(aa_as_tuser))
    else $error("stream_tx_mux: beat changed under back-pressure");

endmodule

`default_nettype wire

// File: project.f
+incdir+hdl
hdl/aa_pkg.sv
hdl/aa_regs.sv
hdl/ls_stream_req.sv
hdl/ss_lite_req.sv
hdl/stream_tx_mux.sv
hdl/aa_bridge.sv
sim/tb_aa_bridge.sv

// File: run_sim.sh
#!/bin/sh
# build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_aa_bridge

out=$(./obj_dir/Vtb_aa_bridge 2>&1) || true
echo "$out"

if echo "$out" | grep -qF '>>> PASS'; then
  exit 0
fi
exit 1

// File: sim/tb_aa_bridge.sv
// --------------------
// testbench of the AXI-Lite / AXI-Stream bridge
// random-ready responders, stream source, concurrent checks
// --------------------
`default_nettype none
`include "aa_defs.svh"

module tb_aa_bridge import aa_pkg::*; ();

  // about 400 cycles of traffic, limit leaves a wide margin
  localparam int CYCLE_LIMIT = 3000;

  logic                   axis_clk, axis_rst_n, cc_aa_enable;
  logic                   s_awvalid, s_wvalid, s_arvalid, s_rready;
  logic [`AA_LADDR_W-1:0] s_awaddr, s_araddr;
  aa_word_t               s_wdata, s_rdata;
  aa_strb_t               s_wstrb;
  logic                   s_awready, s_wready, s_arready, s_rvalid;
  logic                   m_awvalid, m_wvalid, m_arvalid, m_rready;
  aa_word_t               m_awaddr, m_wdata, m_araddr, m_rdata;
  aa_strb_t               m_wstrb;
  logic                   m_awready, m_wready, m_arready, m_rvalid;
  logic                   as_aa_tvalid, aa_as_tready, aa_as_tvalid, as_aa_tready;
  aa_word_t               as_aa_tdata, aa_as_tdata;
  aa_strb_t               as_aa_tstrb, aa_as_tstrb;
  aa_tuser_e              as_aa_tuser, aa_as_tuser;
  logic                   mb_irq;

  // expected outgoing beats, written by stimulus and consumed on transfer
  aa_word_t  exp_data [16];
  aa_strb_t  exp_strb [16];
  aa_tuser_e exp_user [16];
  logic [3:0] beat_wr, beat_rd;
  aa_word_t  mbox_model [`AA_MBOX_DEPTH];
  aa_word_t  exp_rdata, exp_maddr, exp_mwdata;
  aa_strb_t  exp_mwstrb;
  logic      ack_first, reg_wr, irq_check, exp_irq, gate_hold, rst_check;
  logic [31:0] rng;
  int        cycles;

  aa_bridge DUT (.*);

  always #20 axis_clk = ~axis_clk;

  task automatic abort_run(input string line);
    $display("%s", line);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // byte lanes with a strobe bit take the new value
  function automatic aa_word_t merge_bytes(input aa_word_t old_w, input aa_word_t new_w,
                                           input aa_strb_t strb);
    aa_word_t w;
    w = old_w;
    for (int b = 0; b < `AA_STRB_W; b++) begin
      if (strb[b]) w[8*b +: 8] = new_w[8*b +: 8];
    end
    return w;
  endfunction

  // --------------------
  // responders
  // --------------------
  // stream sink ready and AXI-Lite slave, all random from one generator
  initial begin
    rng = 32'h19c1;
    as_aa_tready = 1'b0;
    m_awready = 1'b0;
    m_wready = 1'b0;
    m_arready = 1'b0;
    m_rvalid = 1'b0;
    m_rdata = '0;
    forever begin
      @(negedge axis_clk);
      rng = xorshift(rng);
      as_aa_tready = rng[3] | rng[4];
      // aw and w accepted together
      m_awready = m_awvalid & rng[0];
      m_wready = m_awready;
      m_arready = m_arvalid & rng[1];
      if (!m_rready) m_rvalid = 1'b0;
      else if (!m_rvalid && rng[2]) begin
        m_rvalid = 1'b1;
        m_rdata = xorshift(rng ^ 32'h5a5a);
      end
    end
  end

  always @(posedge axis_clk) begin
    if (!axis_rst_n) beat_rd <= 4'd0;
    else if (aa_as_tvalid && as_aa_tready) beat_rd <= beat_rd + 4'd1;
  end

  always @(posedge axis_clk) begin
    if (!axis_rst_n) begin
      cycles <= 0;
    end else begin
      cycles <= cycles + 1;
      if (cycles == CYCLE_LIMIT)
        abort_run("timeout: the tests did not finish within the cycle limit");
    end
  end

  // --------------------
  // checks
  // --------------------
  a_rst_quiet: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    rst_check |-> !(aa_as_tvalid || aa_as_tready || s_awready || s_wready || s_arready ||
                    s_rvalid || m_awvalid || m_wvalid || m_arvalid || m_rready || mb_irq))
    else abort_run($sformatf("FAILED at %0t: outputs not idle after reset", $time));
  a_beat_expected: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    aa_as_tvalid && as_aa_tready |-> beat_rd != beat_wr)
    else abort_run($sformatf("FAILED at %0t: unexpected stream beat", $time));
  a_beat_value: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    aa_as_tvalid && as_aa_tready |-> aa_as_tdata == exp_data[beat_rd] &&
      aa_as_tstrb == exp_strb[beat_rd] && aa_as_tuser == exp_user[beat_rd])
    else abort_run($sformatf("FAILED at %0t: beat %0d data %h, expected %h", $time,
                             beat_rd, aa_as_tdata, exp_data[beat_rd]));
  // forwarded writes ack after both beats, mailbox writes before them
  a_ack_order: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    s_awready |-> s_wready && (ack_first ? beat_rd != beat_wr : beat_rd == beat_wr))
    else abort_run($sformatf("FAILED at %0t: write ack out of order with its beats", $time));
  a_reg_wr_latency: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    s_awready && reg_wr |-> $past(s_awvalid && s_wvalid, 2) && !$past(s_awvalid, 3))
    else abort_run($sformatf("FAILED at %0t: register write ack not 2 cycles after start",
                             $time));
  a_rdata: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    s_rvalid && s_rready |-> s_rdata == exp_rdata)
    else abort_run($sformatf("FAILED at %0t: read data %h, expected %h", $time,
                             s_rdata, exp_rdata));
  a_master_wr: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    m_awvalid && m_awready && m_wready |-> m_wvalid && m_awaddr == exp_maddr &&
      m_wdata == exp_mwdata && m_wstrb == exp_mwstrb)
    else abort_run($sformatf("FAILED at %0t: master write %h/%h, expected %h/%h", $time,
                             m_awaddr, m_wdata, exp_maddr, exp_mwdata));
  a_master_rd: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    m_arvalid && m_arready |-> m_araddr == exp_maddr)
    else abort_run($sformatf("FAILED at %0t: master read address %h, expected %h", $time,
                             m_araddr, exp_maddr));
  a_irq: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    irq_check |-> mb_irq == exp_irq)
    else abort_run($sformatf("FAILED at %0t: mb_irq is %b, expected %b", $time,
                             mb_irq, exp_irq));
  a_gate: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    gate_hold |-> !s_arready && !s_rvalid)
    else abort_run($sformatf("FAILED at %0t: read accepted while disabled", $time));

  // --------------------
  // stimulus tasks, all called on a falling edge
  // --------------------
  task automatic push_beat(input aa_word_t data, input aa_tuser_e user, input aa_strb_t strb);
    exp_data[beat_wr] = data;
    exp_user[beat_wr] = user;
    exp_strb[beat_wr] = strb;
    beat_wr = beat_wr + 4'd1;
  endtask

  task automatic wait_drained();
    while (beat_rd != beat_wr) @(negedge axis_clk);
  endtask

  task automatic send_beat(input aa_word_t data, input aa_tuser_e user, input aa_strb_t strb);
    as_aa_tvalid = 1'b1;
    as_aa_tdata = data;
    as_aa_tuser = user;
    as_aa_tstrb = strb;
    do @(posedge axis_clk); while (!aa_as_tready);
    @(negedge axis_clk);
    as_aa_tvalid = 1'b0;
  endtask

  task automatic local_write(input logic [`AA_LADDR_W-1:0] addr, input aa_word_t data,
                             input aa_strb_t strb);
    logic win;
    logic mbox;
    win = (addr[14:12] == `AA_WIN_BLOCK);
    mbox = win && (addr[11:8] == `AA_WIN_MBOX);
    reg_wr = win;
    ack_first = mbox;
    // mailbox and outside-window writes both leave as a beat pair
    if (!win || mbox) begin
      push_beat({strb, {(`AA_RADDR_W-`AA_LADDR_W){1'b0}}, addr}, TU_WRITE, strb);
      push_beat(data, TU_WRITE, strb);
    end
    if (mbox) mbox_model[addr[4:2]] = merge_bytes(mbox_model[addr[4:2]], data, strb);
    s_awvalid = 1'b1;
    s_wvalid = 1'b1;
    s_awaddr = addr;
    s_wdata = data;
    s_wstrb = strb;
    do @(posedge axis_clk); while (!s_awready);
    @(negedge axis_clk);
    s_awvalid = 1'b0;
    s_wvalid = 1'b0;
    @(negedge axis_clk);
  endtask

  task automatic local_read(input logic [`AA_LADDR_W-1:0] addr, input aa_word_t expected);
    exp_rdata = expected;
    if (addr[14:12] != `AA_WIN_BLOCK)
      push_beat({{(`AA_DATA_W-`AA_LADDR_W){1'b0}}, addr}, TU_RD_REQ, 4'hf);
    s_arvalid = 1'b1;
    s_araddr = addr;
    do @(posedge axis_clk); while (!s_arready);
    @(negedge axis_clk);
    s_arvalid = 1'b0;
    do @(posedge axis_clk); while (!s_rvalid);
    @(negedge axis_clk);
  endtask

  task automatic remote_write(input logic [`AA_RADDR_W-1:0] addr, input aa_word_t data,
                              input aa_strb_t strb, input logic to_master);
    exp_maddr = {{(`AA_DATA_W-`AA_RADDR_W){1'b0}}, addr};
    exp_mwdata = data;
    exp_mwstrb = strb;
    if (addr[`AA_RADDR_W-1:8] == `AA_REMOTE_MBOX)
      mbox_model[addr[4:2]] = merge_bytes(mbox_model[addr[4:2]], data, strb);
    send_beat({strb, addr}, TU_WRITE, strb);
    send_beat(data, TU_WRITE, strb);
    if (to_master) begin
      do @(posedge axis_clk); while (!(m_awvalid && m_awready && m_wready));
    end
    // register targets land one cycle after the data beat
    @(negedge axis_clk);
  endtask

  task automatic remote_read(input logic [`AA_RADDR_W-1:0] addr);
    aa_word_t word;
    exp_maddr = {{(`AA_DATA_W-`AA_RADDR_W){1'b0}}, addr};
    send_beat({{(`AA_DATA_W-`AA_RADDR_W){1'b0}}, addr}, TU_RD_REQ, 4'hf);
    do @(posedge axis_clk); while (!(m_rvalid && m_rready));
    word = m_rdata;
    @(negedge axis_clk);
    push_beat(word, TU_RD_CPL, 4'hf);
    wait_drained();
  endtask

  task automatic check_irq(input logic level);
    exp_irq = level;
    irq_check = 1'b1;
    @(negedge axis_clk);
    irq_check = 1'b0;
  endtask

  // --------------------
  // test sequence
  // --------------------
  initial begin
    axis_clk = 1'b0;
    axis_rst_n = 1'b0;
    cc_aa_enable = 1'b1;
    {s_awvalid, s_wvalid, s_arvalid} = 3'b000;
    s_rready = 1'b1;
    s_awaddr = '0;
    s_araddr = '0;
    s_wdata = '0;
    s_wstrb = '0;
    as_aa_tvalid = 1'b0;
    as_aa_tdata = '0;
    as_aa_tstrb = '0;
    as_aa_tuser = TU_WRITE;
    beat_wr = 4'd0;
    {ack_first, reg_wr, irq_check, exp_irq, gate_hold, rst_check} = 6'd0;
    exp_rdata = '0;
    exp_maddr = '0;
    exp_mwdata = '0;
    exp_mwstrb = '0;
    repeat (16) @(negedge axis_clk);
    axis_rst_n = 1'b1;
    rst_check = 1'b1;
    @(negedge axis_clk);
    rst_check = 1'b0;

    // forwarded write, then forwarded read answered by a completion
    local_write(15'h1010, 32'h0f1e_2d3c, 4'hb);
    wait_drained();
    fork
      local_read(15'h1020, 32'h5a3c_96e1);
      send_beat(32'h5a3c_96e1, TU_RD_CPL, 4'hf);
    join

    // remote write and read through the AXI-Lite master
    remote_write(28'h0345678, 32'hc001_d00d, 4'h6, 1'b1);
    remote_read(28'h0123450);

    // mailbox word 2, full then partial strobe
    local_write(15'h2008, 32'h1122_3344, 4'hf);
    wait_drained();
    local_write(15'h2008, 32'haabb_ccdd, 4'h5);
    wait_drained();
    local_read(15'h2008, mbox_model[2]);

    // interrupt, enable then remote mailbox write then clear
    local_write(15'h2100, 32'h1, 4'h1);
    check_irq(1'b0);
    remote_write(28'h0002004, 32'h0000_00ff, 4'hf, 1'b0);
    check_irq(1'b1);
    local_write(15'h2104, 32'h1, 4'h1);
    check_irq(1'b0);

    // read held off while disabled
    cc_aa_enable = 1'b0;
    gate_hold = 1'b1;
    fork
      local_read(15'h2008, mbox_model[2]);
      begin
        repeat (20) @(negedge axis_clk);
        gate_hold = 1'b0;
        cc_aa_enable = 1'b1;
      end
    join

    @(negedge axis_clk);
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire
